/* Makefile */
# Verilator build and run for qla_board
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_qla_board
FILELIST  = qla_board.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Test completed successfully
SRCS      = $(filter-out +incdir+%,$(shell cat $(FILELIST))) verilog/qla_board_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* qla_board.f */
+incdir+verilog
verilog/qla_board_pkg.sv
verilog/axis_regs.sv
verilog/block_sampler.sv
verilog/sample_buffer.sv
verilog/reg_read_port.sv
verilog/qla_board_top.sv
sim/tb_qla_board.sv

/* sim/tb_qla_board.sv */
// qla board testbench
`include "qla_board_cfg.svh"

module tb_qla_board;
    timeunit 1ns;
    timeprecision 1ps;
    import qla_board_pkg::*;

    localparam int timeout_cycles = 4000;   // full sequence takes about 330 cycles

    logic                    sysclk;
    logic                    arst_n;
    logic [`QLA_ADDR_W-1:0]  reg_raddr;
    logic [`QLA_ADDR_W-1:0]  reg_waddr;
    logic [`QLA_DATA_W-1:0]  reg_wdata;
    logic                    reg_wen;
    logic [`QLA_DATA_W-1:0]  reg_rdata;
    axis_words_t             cur_fb;
    logic                    cur_ready;
    axis_words_t             cur_cmd;
    logic [`QLA_NUM_AXES-1:0] amp_en;
    logic                    sample_start;
    logic                    sample_busy;

    // ----------------------------------------
    // reference state
    // ----------------------------------------
    logic [15:0]  ref_cmd [1:4];
    logic [15:0]  ref_fb [1:4];
    logic [3:0]   ref_en;
    logic [3:0]   ref_latch;
    logic [7:0]   ref_seq;        // captures since reset
    logic [31:0]  ref_buf [16];

    integer       seed;
    int           cycles;
    logic         rd_valid;       // read issued this cycle
    logic [31:0]  rd_exp;
    logic         chk_valid;      // read data due now
    logic [31:0]  chk_exp;
    axis_words_t  fb;

    qla_board_top u_dut (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .reg_rdata    (reg_rdata),
        .cur_fb       (cur_fb),
        .cur_ready    (cur_ready),
        .cur_cmd      (cur_cmd),
        .amp_en       (amp_en),
        .sample_start (sample_start),
        .sample_busy  (sample_busy)
    );

    always #10 sysclk = ~sysclk;    // 20 ns period

    function automatic logic [15:0] reg_addr(input logic [3:0] space, input logic [3:0] chan,
                                             input logic [3:0] off);
        return {space, 4'h0, chan, off};
    endfunction

    function automatic logic [31:0] ref_status();
        return {16'h0, ref_seq, ref_latch, ref_en};
    endfunction

    // expected read data for an address, from the register map
    function automatic logic [31:0] ref_read(input logic [15:0] addr);
        logic [3:0] chan;
        logic [3:0] off;
        chan = addr[7:4];
        off  = addr[3:0];
        if (addr[15:12] == ADDR_DATA_BUF) return ref_buf[off];
        if (addr[15:12] != ADDR_MAIN) return 32'h0;     // unknown space
        if (chan == 4'd0) return (off == 4'd0) ? ref_status() : 32'h0;
        if (chan > 4'd4) return 32'h0;
        if (off == OFF_ADC_DATA) return {16'h0, ref_fb[chan]};
        if (off == OFF_DAC_CTRL) return {16'h0, ref_cmd[chan]};
        return 32'h0;
    endfunction

    task automatic check_val(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // read data is stable at the second rising edge after the address
    always @(posedge sysclk) begin
        if (chk_valid) check_val("reg_rdata", reg_rdata, chk_exp);
        chk_valid <= rd_valid;
        chk_exp   <= rd_exp;
    end

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // bus tasks
    // ----------------------------------------
    task automatic do_write(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        reg_waddr = addr;
        reg_wdata = data;
        reg_wen   = 1'b1;
        if (addr[15:12] == ADDR_MAIN && addr[7:4] == 4'd0 && addr[3:0] == 4'd0) begin
            ref_en    = data[3:0];
            ref_latch = ref_latch & ~data[3:0];   // re-enable releases the latch
        end else if (addr[15:12] == ADDR_MAIN && addr[7:4] >= 4'd1 && addr[7:4] <= 4'd4
                     && addr[3:0] == OFF_DAC_CTRL) begin
            ref_cmd[addr[7:4]] = data[15:0];
        end
        @(negedge sysclk);
        reg_wen = 1'b0;
    endtask

    task automatic do_read(input logic [15:0] addr);
        @(negedge sysclk);
        reg_raddr = addr;
        rd_exp    = ref_read(addr);
        rd_valid  = 1'b1;
        @(negedge sysclk);
        rd_valid = 1'b0;
    endtask

    // adc strobe, then the safety rule on the new feedback
    task automatic apply_feedback(input axis_words_t value);
        @(negedge sysclk);
        cur_fb    = value;
        cur_ready = 1'b1;
        @(negedge sysclk);
        cur_ready = 1'b0;
        for (int n = 1; n <= 4; n++) begin
            ref_fb[n] = value[n];
            if (ref_en[n-1] && int'(value[n]) > 2 * int'(ref_cmd[n]) + `QLA_SAFETY_MARGIN)
                ref_latch[n-1] = 1'b1;
        end
        @(negedge sysclk);      // latch visible two cycles after the strobe
        check_val("amp_en", {28'h0, amp_en}, {28'h0, ref_en & ~ref_latch});
    endtask

    // one capture, optionally with a start pulse while busy
    task automatic run_capture(input bit extra_pulse);
        @(negedge sysclk);
        sample_start = 1'b1;
        ref_seq      = ref_seq + 8'd1;
        ref_buf[0]   = {24'h0, ref_seq};
        ref_buf[1]   = ref_status();
        for (int n = 1; n <= 4; n++) begin
            ref_buf[2*n]   = {16'h0, ref_fb[n]};
            ref_buf[2*n+1] = {16'h0, ref_cmd[n]};
        end
        @(negedge sysclk);
        sample_start = 1'b0;
        check_val("sample_busy", {31'h0, sample_busy}, 32'h1);
        if (extra_pulse) begin
            @(negedge sysclk);
            sample_start = 1'b1;                // ignored, capture in progress
            @(negedge sysclk);
            sample_start = 1'b0;
            check_val("sample_busy", {31'h0, sample_busy}, 32'h1);
        end
        while (sample_busy) @(negedge sysclk);
        for (int k = 0; k < 16; k++) do_read(reg_addr(ADDR_DATA_BUF, 4'h0, 4'(k)));
    endtask

    task automatic write_random_cmds(input logic [31:0] mask);
        for (int n = 1; n <= 4; n++) begin
            do_write(reg_addr(ADDR_MAIN, 4'(n), OFF_DAC_CTRL), $random(seed) & mask);
            check_val("cur_cmd", {16'h0, cur_cmd[n]}, {16'h0, ref_cmd[n]});
            do_read(reg_addr(ADDR_MAIN, 4'(n), OFF_DAC_CTRL));
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed = 7912;
        sysclk = 1'b0;
        arst_n = 1'b0;
        reg_raddr = '0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_wen = 1'b0;
        cur_fb = '0;
        cur_ready = 1'b0;
        sample_start = 1'b0;
        rd_valid = 1'b0;
        rd_exp = '0;
        chk_valid = 1'b0;
        chk_exp = '0;
        cycles = 0;
        ref_en = '0;
        ref_latch = '0;
        ref_seq = '0;
        for (int n = 1; n <= 4; n++) begin
            ref_cmd[n] = '0;
            ref_fb[n] = '0;
        end
        for (int k = 0; k < 16; k++) ref_buf[k] = '0;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        arst_n = 1'b1;

        // reset values
        check_val("amp_en", {28'h0, amp_en}, 32'h0);
        check_val("sample_busy", {31'h0, sample_busy}, 32'h0);
        do_read(reg_addr(ADDR_MAIN, 4'h0, 4'h0));
        for (int n = 1; n <= 4; n++) do_read(reg_addr(ADDR_MAIN, 4'(n), OFF_DAC_CTRL));
        for (int k = 0; k < 16; k++) do_read(reg_addr(ADDR_DATA_BUF, 4'h0, 4'(k)));

        write_random_cmds(32'hffff_ffff);     // upper half dropped
        write_random_cmds(32'hffff_ffff);

        // feedback readback, amps still off
        for (int n = 1; n <= 4; n++) fb[n] = $random(seed);
        apply_feedback(fb);
        for (int n = 1; n <= 4; n++) do_read(reg_addr(ADDR_MAIN, 4'(n), OFF_ADC_DATA));
        do_read(reg_addr(ADDR_MAIN, 4'h5, OFF_ADC_DATA));   // no axis 5
        do_read(reg_addr(ADDR_MAIN, 4'h1, 4'h2));           // unused offset
        do_read(reg_addr(ADDR_MAIN, 4'h0, 4'h1));
        do_read(reg_addr(4'h3, 4'h1, OFF_ADC_DATA));        // unknown space

        // safety trip on axis 2 only
        do_write(reg_addr(ADDR_MAIN, 4'h0, 4'h0), 32'hf);
        write_random_cmds(32'h0000_3fff);
        for (int n = 1; n <= 4; n++) fb[n] = ref_cmd[n];
        fb[2] = {ref_cmd[2][14:0], 1'b0} + `QLA_SAFETY_MARGIN + 16'd1;
        apply_feedback(fb);
        check_val("amp_en", {28'h0, amp_en}, 32'hd);
        do_read(reg_addr(ADDR_MAIN, 4'h0, 4'h0));
        do_write(reg_addr(ADDR_MAIN, 4'h0, 4'h0), 32'hf);
        check_val("amp_en", {28'h0, amp_en}, 32'hf);
        do_read(reg_addr(ADDR_MAIN, 4'h0, 4'h0));

        // block sampling, then a second capture with new values
        run_capture(1'b0);
        write_random_cmds(32'h0000_ffff);
        for (int n = 1; n <= 4; n++) fb[n] = $random(seed);
        apply_feedback(fb);
        run_capture(1'b0);

        // start while busy is dropped
        run_capture(1'b1);
        run_capture(1'b0);
        do_read(reg_addr(ADDR_MAIN, 4'h0, 4'h0));

        repeat (3) @(negedge sysclk);       // let the last read compare
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/axis_regs.sv */
// axis registers and safety check
`include "qla_board_cfg.svh"

module axis_regs (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic [`QLA_ADDR_W-1:0]      reg_waddr,
    input  logic [`QLA_DATA_W-1:0]      reg_wdata,
    input  logic                        reg_wen,
    input  qla_board_pkg::axis_words_t  cur_fb,
    input  logic                        cur_ready,     // adc result strobe
    input  logic [7:0]                  seq_num,
    output qla_board_pkg::axis_words_t  cur_cmd,
    output qla_board_pkg::axis_words_t  fb_hold,
    output logic [`QLA_NUM_AXES-1:0]    amp_en,
    output logic [`QLA_DATA_W-1:0]      status_word
);
    import qla_board_pkg::*;

    logic [3:0]               wr_space;
    logic [3:0]               wr_chan;
    logic [3:0]               wr_off;
    logic                     main_wr;
    logic                     en_wr;           // enable mask write
    logic [`QLA_NUM_AXES-1:0] enable_mask;
    logic [`QLA_NUM_AXES-1:0] latch;           // safety amp disable, per axis
    logic [`QLA_NUM_AXES-1:0] trip;
    logic [`QLA_NUM_AXES-1:0] clear;
    logic                     check_pend;      // fb_hold freshly captured

    // ----------------------------------------
    // write decode
    // ----------------------------------------
    assign wr_space = reg_waddr[`QLA_SPACE_MSB:`QLA_SPACE_LSB];
    assign wr_chan  = reg_waddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign wr_off   = reg_waddr[`QLA_OFF_MSB:`QLA_OFF_LSB];
    assign main_wr  = reg_wen && (wr_space == ADDR_MAIN);
    assign en_wr    = main_wr && (wr_chan == 4'd0) && (wr_off == 4'd0); // board status reg
    assign clear    = en_wr ? reg_wdata[`QLA_NUM_AXES-1:0] : '0;   // re-enable clears latch

    // command registers, axes 1..4
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= '0;
        end else begin
            for (int n = 1; n <= `QLA_NUM_AXES; n++) begin
                if (main_wr && (wr_chan == n) && (wr_off == OFF_DAC_CTRL)) begin
                    cur_cmd[n] <= reg_wdata[`QLA_AXIS_W-1:0];   // low half only
                end
            end
        end
    end

    // ----------------------------------------
    // feedback capture, enables, latches
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            fb_hold     <= '0;
            check_pend  <= 1'b0;
            enable_mask <= '0;
            latch       <= '0;
        end else begin
            check_pend <= cur_ready;                // check one cycle after capture
            if (cur_ready) begin
                fb_hold <= cur_fb;
            end
            if (en_wr) begin
                enable_mask <= reg_wdata[`QLA_NUM_AXES-1:0];
            end
            latch <= (latch & ~clear) | trip;       // a trip wins over a clear
        end
    end

    // one comparator per axis, unsigned 18 bit
    for (genvar n = 1; n <= `QLA_NUM_AXES; n++) begin : g_safety
        logic [17:0] fb_ext;
        logic [17:0] limit;      // 2*cmd + margin

        assign fb_ext = {2'b00, fb_hold[n]};
        assign limit  = {1'b0, cur_cmd[n], 1'b0} + {2'b00, `QLA_SAFETY_MARGIN};
        assign trip[n-1] = check_pend && enable_mask[n-1] && (fb_ext > limit);

        // a held latch keeps the amplifier off in the following cycle
        a_latch_holds_off: assert property (@(posedge sysclk) disable iff (!arst_n)
            (latch[n-1] && !clear[n-1]) |=> !amp_en[n-1]);
    end

    assign amp_en = enable_mask & ~latch;

    // status: enables, latches, seq low byte
    assign status_word = {{(`QLA_DATA_W - 8 - 2*`QLA_NUM_AXES){1'b0}},
                          seq_num, latch, enable_mask};

endmodule

/* verilog/block_sampler.sv */
// block sampler
`include "qla_board_cfg.svh"

module block_sampler (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        sample_start,
    input  logic [`QLA_DATA_W-1:0]      status_word,
    input  qla_board_pkg::axis_words_t  fb_hold,
    input  qla_board_pkg::axis_words_t  cur_cmd,
    output logic                        busy,
    output logic [7:0]                  seq_num,
    output logic                        buf_wen,
    output logic [`QLA_BUF_AW-1:0]      buf_waddr,
    output logic [`QLA_DATA_W-1:0]      buf_wdata
);
    import qla_board_pkg::*;

    localparam int last_idx = `QLA_SAMPLE_WORDS - 1;

    sampler_state_e          state;
    logic [`QLA_BUF_AW-1:0]  widx;         // word being written
    logic [2:0]              axis_sel;     // 1..4 during S_AXES
    logic                    last_word;

    assign busy      = (state != S_IDLE);
    assign buf_wen   = busy;               // one word per busy cycle
    assign buf_waddr = widx;
    assign axis_sel  = widx[`QLA_BUF_AW-1:1];   // words 2,3 -> axis 1 ... 8,9 -> axis 4
    assign last_word = (widx == last_idx[`QLA_BUF_AW-1:0]);

    // ----------------------------------------
    // snapshot word select
    // ----------------------------------------
    always_comb begin
        case (state)
            S_HEAD: begin
                if (widx[0]) begin
                    buf_wdata = status_word;
                end else begin
                    buf_wdata = {{(`QLA_DATA_W-8){1'b0}}, seq_num};
                end
            end
            S_AXES: begin
                if (widx[0]) begin                  // odd word is the command
                    buf_wdata = {{(`QLA_DATA_W-`QLA_AXIS_W){1'b0}}, cur_cmd[axis_sel]};
                end else begin                      // even word is the adc word
                    buf_wdata = {{(`QLA_DATA_W-`QLA_AXIS_W){1'b0}}, fb_hold[axis_sel]};
                end
            end
            default: buf_wdata = '0;
        endcase
    end

    // ----------------------------------------
    // FSM
    // ----------------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= S_IDLE;
            widx    <= '0;
            seq_num <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (sample_start) begin         // starts only from idle
                        state   <= S_HEAD;
                        widx    <= '0;
                        seq_num <= seq_num + 8'd1;  // first capture is 1
                    end
                end
                S_HEAD: begin
                    widx <= widx + 1'b1;
                    if (widx[0]) begin
                        state <= S_AXES;
                    end
                end
                S_AXES: begin
                    if (last_word) begin
                        state <= S_IDLE;
                        widx  <= '0;
                    end else begin
                        widx <= widx + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // capture lasts exactly one snapshot
    a_busy_len: assert property (@(posedge sysclk) disable iff (!arst_n)
        $rose(busy) |-> busy [*`QLA_SAMPLE_WORDS] ##1 !busy);

    a_waddr_range: assert property (@(posedge sysclk) disable iff (!arst_n)
        buf_wen |-> (buf_waddr < `QLA_SAMPLE_WORDS));

endmodule

/* verilog/qla_board_cfg.svh */
// qla board configuration
`ifndef QLA_BOARD_CFG_SVH
`define QLA_BOARD_CFG_SVH

// register bus
`define QLA_DATA_W          32          // register data width
`define QLA_ADDR_W          16          // register address width

// address field positions
`define QLA_SPACE_MSB       15          // address space field
`define QLA_SPACE_LSB       12
`define QLA_CHAN_MSB        7           // channel field, 0 is the board
`define QLA_CHAN_LSB        4
`define QLA_OFF_MSB         3           // offset within a channel
`define QLA_OFF_LSB         0

// axes
`define QLA_NUM_AXES        4
`define QLA_AXIS_W          16          // feedback and command width
`define QLA_SAFETY_MARGIN   16'h0100    // added to twice the command

// sample buffer
`define QLA_BUF_DEPTH       16
`define QLA_BUF_AW          4
`define QLA_SAMPLE_WORDS    10          // seq, status, adc+cmd per axis

`endif

/* verilog/qla_board_pkg.sv */
// qla board shared types
`include "qla_board_cfg.svh"

package qla_board_pkg;

    // ----------------------------------------
    // address decode
    // ----------------------------------------

    // bits 15..12 of a register address
    typedef enum logic [3:0] {
        ADDR_MAIN     = 4'h0,   // board and axis registers
        ADDR_DATA_BUF = 4'h5    // sample buffer words
    } addr_space_e;

    // bits 3..0 within an axis channel
    // on channel 0, offset 0 is the status register
    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'h0,    // captured feedback
        OFF_DAC_CTRL = 4'h1     // current command
    } chan_off_e;

    // ----------------------------------------
    // sampler
    // ----------------------------------------

    typedef enum logic [1:0] {
        S_IDLE,                 // waiting for start
        S_HEAD,                 // sequence and status words
        S_AXES                  // adc and command per axis
    } sampler_state_e;

    // one word per axis, axis 1 first
    typedef logic [1:`QLA_NUM_AXES][`QLA_AXIS_W-1:0] axis_words_t;

endpackage

/* verilog/qla_board_top.sv */
// qla board top level
`include "qla_board_cfg.svh"

module qla_board_top (
    input  logic                        sysclk,
    input  logic                        arst_n,
    // host register bus
    input  logic [`QLA_ADDR_W-1:0]      reg_raddr,
    input  logic [`QLA_ADDR_W-1:0]      reg_waddr,
    input  logic [`QLA_DATA_W-1:0]      reg_wdata,
    input  logic                        reg_wen,
    output logic [`QLA_DATA_W-1:0]      reg_rdata,
    // adc side
    input  qla_board_pkg::axis_words_t  cur_fb,
    input  logic                        cur_ready,
    // amplifier side
    output qla_board_pkg::axis_words_t  cur_cmd,
    output logic [`QLA_NUM_AXES-1:0]    amp_en,
    // block sampling
    input  logic                        sample_start,
    output logic                        sample_busy
);
    import qla_board_pkg::*;

    axis_words_t             fb_hold;       // feedback held since last cur_ready
    logic [`QLA_DATA_W-1:0]  status_word;
    logic [7:0]              seq_num;       // capture count
    logic                    buf_wen;
    logic [`QLA_BUF_AW-1:0]  buf_waddr;
    logic [`QLA_DATA_W-1:0]  buf_wdata;
    logic [`QLA_BUF_AW-1:0]  buf_raddr;
    logic [`QLA_DATA_W-1:0]  buf_rdata;

    // ----------------------------------------
    // axis registers and safety
    // ----------------------------------------
    axis_regs u_axis_regs (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_wen     (reg_wen),
        .cur_fb      (cur_fb),
        .cur_ready   (cur_ready),
        .seq_num     (seq_num),
        .cur_cmd     (cur_cmd),
        .fb_hold     (fb_hold),
        .amp_en      (amp_en),
        .status_word (status_word)
    );

    // ----------------------------------------
    // snapshot path
    // ----------------------------------------
    block_sampler u_block_sampler (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .sample_start (sample_start),
        .status_word  (status_word),
        .fb_hold      (fb_hold),
        .cur_cmd      (cur_cmd),
        .busy         (sample_busy),
        .seq_num      (seq_num),
        .buf_wen      (buf_wen),
        .buf_waddr    (buf_waddr),
        .buf_wdata    (buf_wdata)
    );

    sample_buffer u_sample_buffer (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .buf_wen   (buf_wen),
        .buf_waddr (buf_waddr),
        .buf_wdata (buf_wdata),
        .buf_raddr (buf_raddr),
        .buf_rdata (buf_rdata)
    );

    // host reads, one cycle latency
    reg_read_port u_reg_read_port (
        .sysclk      (sysclk),
        .arst_n      (arst_n),
        .reg_raddr   (reg_raddr),
        .status_word (status_word),
        .fb_hold     (fb_hold),
        .cur_cmd     (cur_cmd),
        .buf_rdata   (buf_rdata),
        .buf_raddr   (buf_raddr),
        .reg_rdata   (reg_rdata)
    );

endmodule

/* verilog/reg_read_port.sv */
// register read port
`include "qla_board_cfg.svh"

module reg_read_port (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic [`QLA_ADDR_W-1:0]      reg_raddr,
    input  logic [`QLA_DATA_W-1:0]      status_word,
    input  qla_board_pkg::axis_words_t  fb_hold,
    input  qla_board_pkg::axis_words_t  cur_cmd,
    input  logic [`QLA_DATA_W-1:0]      buf_rdata,
    output logic [`QLA_BUF_AW-1:0]      buf_raddr,
    output logic [`QLA_DATA_W-1:0]      reg_rdata
);
    import qla_board_pkg::*;

    logic [3:0]              rd_space;
    logic [3:0]              rd_chan;
    logic [3:0]              rd_off;
    logic [`QLA_DATA_W-1:0]  main_word;    // board or axis register
    logic [`QLA_DATA_W-1:0]  main_q;
    logic [3:0]              space_q;      // space of the pending read

    assign rd_space  = reg_raddr[`QLA_SPACE_MSB:`QLA_SPACE_LSB];
    assign rd_chan   = reg_raddr[`QLA_CHAN_MSB:`QLA_CHAN_LSB];
    assign rd_off    = reg_raddr[`QLA_OFF_MSB:`QLA_OFF_LSB];
    assign buf_raddr = reg_raddr[`QLA_BUF_AW-1:0];   // word k at bits 3..0

    // ----------------------------------------
    // main space mux
    // ----------------------------------------
    always_comb begin
        main_word = '0;                             // unknown space, chan, offset
        if (rd_space == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_off == 4'd0) begin
                    main_word = status_word;
                end
            end else if (rd_chan <= `QLA_NUM_AXES) begin
                case (rd_off)
                    OFF_ADC_DATA: main_word = {{(`QLA_DATA_W-`QLA_AXIS_W){1'b0}},
                                               fb_hold[rd_chan]};
                    OFF_DAC_CTRL: main_word = {{(`QLA_DATA_W-`QLA_AXIS_W){1'b0}},
                                               cur_cmd[rd_chan]};
                    default:      main_word = '0;
                endcase
            end
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            main_q  <= '0;
            space_q <= ADDR_MAIN;
        end else begin
            main_q  <= main_word;
            space_q <= rd_space;
        end
    end

    // buffer word arrives registered in the same cycle
    assign reg_rdata = (space_q == ADDR_DATA_BUF) ? buf_rdata : main_q;

endmodule

/* verilog/sample_buffer.sv */
// sample buffer memory
`include "qla_board_cfg.svh"

module sample_buffer (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        buf_wen,
    input  logic [`QLA_BUF_AW-1:0]      buf_waddr,
    input  logic [`QLA_DATA_W-1:0]      buf_wdata,
    input  logic [`QLA_BUF_AW-1:0]      buf_raddr,
    output logic [`QLA_DATA_W-1:0]      buf_rdata
);

    logic [`QLA_DATA_W-1:0] mem [`QLA_BUF_DEPTH];

    // write port, sampler side
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `QLA_BUF_DEPTH; i++) begin
                mem[i] <= '0;       // unwritten words read 0
            end
        end else if (buf_wen) begin
            mem[buf_waddr] <= buf_wdata;
        end
    end

    // read port, host side
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            buf_rdata <= '0;
        end else begin
            buf_rdata <= mem[buf_raddr];    // registered, lines up with main_q
        end
    end

endmodule
